/* src.f */
+incdir+verilog
verilog/clic_pkg.sv
verilog/clic_timer.sv
verilog/clic_vector_table.sv
verilog/clic_priority_select.sv
verilog/clic_return_stack.sv
verilog/clic_ctrl.sv
verilog/clic_top.sv
testbench/clic_tb.sv

/* testbench/clic_tb.sv */
// clic testbench with table-driven checks of csr access, selection, nesting, return and timer
`timescale 1ns/1ps
`include "clic_macros.svh"

module clic_tb
  import clic_pkg::*;
();

  logic     clk;
  logic     rst_i;
  csr_req_t csr_req_i;
  addr_t    pc_i;
  word_t    csr_rdata_o;
  addr_t    target_addr_o;
  pc_sel_e  pc_sel_o;
  prio_t    level_o;
  logic     irq_o;

  // stimulus table with one row per cycle
  string    names [$];
  csr_req_t reqs [$];
  addr_t    pcs [$];
  logic     exp_irq [$];
  pc_sel_e  exp_sel [$];
  addr_t    exp_tgt [$];
  word_t    exp_rd [$];
  prio_t    exp_lvl [$];

  word_t rng_state   = 32'hb4c7_a888;
  int    cycle_cnt   = 0;
  int    cycle_limit = 0;  // set once the table is built

  clic_top UUT (
    .clk, .rst_i, .csr_req_i, .pc_i,
    .csr_rdata_o, .target_addr_o, .pc_sel_o, .level_o, .irq_o
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  function automatic word_t lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic addr_t rand_pc();
    word_t r;
    r = lcg_next();
    return {r[17:4], 2'b00};  // word aligned so never the return marker
  endfunction

  function automatic vec_addr_t rand_vec();
    word_t r;
    r = lcg_next();
    return r[29:16];
  endfunction

  function automatic csr_req_t make_req(input csr_addr_t a, input csr_op_e op, input word_t d);
    csr_req_t req;
    req.enable = (op != CSR_NONE);
    req.addr   = a;
    req.op     = op;
    req.data   = d;
    return req;
  endfunction

  // entry csr layout is prio, enabled, then pended in the lsb
  function automatic word_t entry_word(input prio_t p, input logic en, input logic pend);
    return word_t'({p, en, pend});
  endfunction

  function automatic addr_t byte_addr(input vec_addr_t v);
    return {v, 2'b00};
  endfunction

  task automatic add_row(input string name, input csr_req_t req, input addr_t pc,
                         input logic irq, input pc_sel_e sel, input addr_t tgt,
                         input word_t rd, input prio_t lvl);
    names.push_back(name);
    reqs.push_back(req);
    pcs.push_back(pc);
    exp_irq.push_back(irq);
    exp_sel.push_back(sel);
    exp_tgt.push_back(tgt);
    exp_rd.push_back(rd);
    exp_lvl.push_back(lvl);
  endtask

  // cpu keeps its own pc when nothing fires
  task automatic quiet_row(input string name, input csr_req_t req, input word_t rd,
                           input prio_t lvl);
    addr_t pc;
    pc = rand_pc();
    add_row(name, req, pc, 1'b0, PC_NORMAL, pc, rd, lvl);
  endtask

  task automatic jump_row(input string name, input addr_t pc, input addr_t tgt,
                          input prio_t lvl);
    add_row(name, make_req('0, CSR_NONE, '0), pc, 1'b1, PC_INTERRUPT, tgt, '0, lvl);
  endtask

  task automatic return_row(input string name, input addr_t tgt, input prio_t lvl);
    add_row(name, make_req('0, CSR_NONE, '0), `RETURN_MARKER, 1'b0, PC_INTERRUPT, tgt,
            '0, lvl);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("error %s: rdata expected %h actual %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "csr read data mismatch");
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("error %s: target expected %h actual %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "target address mismatch");
    end
  endtask

  task automatic check_sel(input string name, input pc_sel_e exp, input pc_sel_e act);
    if (act !== exp) begin
      $display("error %s: pc_sel expected %s actual %s", name, exp.name(), act.name());
      $display("** FAIL **");
      $fatal(1, "pc select mismatch");
    end
  endtask

  task automatic check_level(input string name, input prio_t exp, input prio_t act);
    if (act !== exp) begin
      $display("error %s: level expected %0d actual %0d", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "nesting level mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: irq expected %b actual %b", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "irq mismatch");
    end
  endtask

  task automatic build_table();
    vec_addr_t v0, v1, v2, v3, v4, v5;
    addr_t     pa, pb, pf, pg;
    v0 = rand_vec();
    v1 = rand_vec();
    v2 = rand_vec();
    v3 = rand_vec();
    v4 = rand_vec();
    v5 = rand_vec();
    quiet_row("reset_state", make_req('0, CSR_NONE, '0), '0, 3'd0);
    // csr write, set, clear and readback
    quiet_row("vec1_write", make_req(`VEC_BASE + 12'd1, CSR_WRITE, word_t'(v1)), '0, 3'd0);
    quiet_row("vec1_set", make_req(`VEC_BASE + 12'd1, CSR_SET, 32'h3), word_t'(v1), 3'd0);
    quiet_row("vec1_clear", make_req(`VEC_BASE + 12'd1, CSR_CLEAR, 32'h3),
              word_t'(v1 | 14'h3), 3'd0);
    quiet_row("vec1_restore", make_req(`VEC_BASE + 12'd1, CSR_WRITE, word_t'(v1)),
              word_t'(v1 & ~14'h3), 3'd0);
    quiet_row("vec1_read", make_req(`VEC_BASE + 12'd1, CSR_NONE, '0), word_t'(v1), 3'd0);
    quiet_row("entry1_write", make_req(`ENTRY_BASE + 12'd1, CSR_WRITE,
              entry_word(3'd3, 1'b0, 1'b0)), '0, 3'd0);
    quiet_row("entry1_set", make_req(`ENTRY_BASE + 12'd1, CSR_SET, 32'h1),
              entry_word(3'd3, 1'b0, 1'b0), 3'd0);
    quiet_row("entry1_clear", make_req(`ENTRY_BASE + 12'd1, CSR_CLEAR, 32'h1),
              entry_word(3'd3, 1'b0, 1'b1), 3'd0);
    quiet_row("entry1_read", make_req(`ENTRY_BASE + 12'd1, CSR_NONE, '0),
              entry_word(3'd3, 1'b0, 1'b0), 3'd0);
    quiet_row("thresh_write", make_req(`THRESH_ADDR, CSR_WRITE, 32'd5), '0, 3'd0);
    quiet_row("thresh_set", make_req(`THRESH_ADDR, CSR_SET, 32'd2), 32'd5, 3'd0);
    quiet_row("thresh_clear", make_req(`THRESH_ADDR, CSR_CLEAR, 32'd7), 32'd7, 3'd0);
    quiet_row("unmapped", make_req(12'h123, CSR_WRITE, 32'hffff_ffff), '0, 3'd0);
    // threshold held at 7 so nothing is taken while entries are set up
    quiet_row("thresh_hold", make_req(`THRESH_ADDR, CSR_WRITE, 32'd7), '0, 3'd0);
    quiet_row("vec2_write", make_req(`VEC_BASE + 12'd2, CSR_WRITE, word_t'(v2)), '0, 3'd0);
    quiet_row("vec3_write", make_req(`VEC_BASE + 12'd3, CSR_WRITE, word_t'(v3)), '0, 3'd0);
    quiet_row("vec4_write", make_req(`VEC_BASE + 12'd4, CSR_WRITE, word_t'(v4)), '0, 3'd0);
    quiet_row("vec5_write", make_req(`VEC_BASE + 12'd5, CSR_WRITE, word_t'(v5)), '0, 3'd0);
    quiet_row("entry1_pend", make_req(`ENTRY_BASE + 12'd1, CSR_WRITE,
              entry_word(3'd3, 1'b1, 1'b1)), entry_word(3'd3, 1'b0, 1'b0), 3'd0);
    quiet_row("entry2_pend", make_req(`ENTRY_BASE + 12'd2, CSR_WRITE,
              entry_word(3'd5, 1'b1, 1'b1)), '0, 3'd0);
    quiet_row("entry3_pend", make_req(`ENTRY_BASE + 12'd3, CSR_WRITE,
              entry_word(3'd5, 1'b1, 1'b1)), '0, 3'd0);
    quiet_row("thresh_release", make_req(`THRESH_ADDR, CSR_WRITE, '0), 32'd7, 3'd0);
    pa = rand_pc();
    jump_row("take_tie_high_index", pa, byte_addr(v3), 3'd0);  // entries 2 and 3 tie at 5
    quiet_row("take_clears_pend", make_req(`ENTRY_BASE + 12'd3, CSR_NONE, '0),
              entry_word(3'd5, 1'b1, 1'b0), 3'd1);
    quiet_row("take_thresh", make_req(`THRESH_ADDR, CSR_NONE, '0), 32'd5, 3'd1);
    // nesting
    quiet_row("entry4_pend", make_req(`ENTRY_BASE + 12'd4, CSR_WRITE,
              entry_word(3'd6, 1'b1, 1'b1)), '0, 3'd1);
    pb = rand_pc();
    jump_row("nest_take", pb, byte_addr(v4), 3'd1);
    quiet_row("entry5_pend", make_req(`ENTRY_BASE + 12'd5, CSR_WRITE,
              entry_word(3'd6, 1'b1, 1'b1)), '0, 3'd2);
    quiet_row("equal_prio_waits", make_req(`DEPTH_ADDR, CSR_NONE, '0), 32'd2, 3'd2);
    // return marker
    jump_row("tail_chain", `RETURN_MARKER, byte_addr(v5), 3'd2);
    quiet_row("tail_keeps_level", make_req(`DEPTH_ADDR, CSR_NONE, '0), 32'd2, 3'd2);
    return_row("return_nested", pb, 3'd2);
    quiet_row("thresh_restored", make_req(`THRESH_ADDR, CSR_NONE, '0), 32'd5, 3'd1);
    jump_row("tail_to_entry2", `RETURN_MARKER, byte_addr(v2), 3'd1);
    return_row("return_outer", pa, 3'd1);
    pf = rand_pc();
    jump_row("take_after_return", pf, byte_addr(v1), 3'd0);
    return_row("return_entry1", pf, 3'd1);
    // timer pends entry 0 three cycles after the load and one more for the table
    quiet_row("vec0_write", make_req(`VEC_BASE, CSR_WRITE, word_t'(v0)), '0, 3'd0);
    quiet_row("entry0_enable", make_req(`ENTRY_BASE, CSR_WRITE,
              entry_word(3'd2, 1'b1, 1'b0)), '0, 3'd0);
    quiet_row("timer_load", make_req(`TIMER_ADDR, CSR_WRITE, 32'd3), '0, 3'd0);
    quiet_row("timer_count3", make_req(`TIMER_ADDR, CSR_NONE, '0), 32'd3, 3'd0);
    quiet_row("timer_count2", make_req(`TIMER_ADDR, CSR_NONE, '0), 32'd2, 3'd0);
    quiet_row("timer_count1", make_req(`TIMER_ADDR, CSR_NONE, '0), 32'd1, 3'd0);
    quiet_row("timer_expired", make_req(`TIMER_ADDR, CSR_NONE, '0), '0, 3'd0);
    pg = rand_pc();
    jump_row("timer_take", pg, byte_addr(v0), 3'd0);
    quiet_row("timer_pend_cleared", make_req(`ENTRY_BASE, CSR_NONE, '0),
              entry_word(3'd2, 1'b1, 1'b0), 3'd1);
    return_row("timer_return", pg, 3'd1);
    quiet_row("final_level", make_req(`DEPTH_ADDR, CSR_NONE, '0), '0, 3'd0);
  endtask

  initial begin
    rst_i     = 1'b1;
    csr_req_i = make_req('0, CSR_NONE, '0);
    pc_i      = '0;
    build_table();
    cycle_limit = names.size() + 16 + 50;
    repeat (16) @(posedge clk);
    #1 rst_i = 1'b0;
    for (int i = 0; i < names.size(); i++) begin
      csr_req_i = reqs[i];
      pc_i      = pcs[i];
      #18;  // just before the next rising edge
      check_flag(names[i], exp_irq[i], irq_o);
      check_sel(names[i], exp_sel[i], pc_sel_o);
      check_addr(names[i], exp_tgt[i], target_addr_o);
      check_word(names[i], exp_rd[i], csr_rdata_o);
      check_level(names[i], exp_lvl[i], level_o);
      @(posedge clk);
      #1;
    end
    $display("** PASS **");
    $finish;
  end

endmodule

/* verilog/clic_ctrl.sv */
// clic ctrl holds the threshold csr, the take/tail/return decision and the csr read mux
`timescale 1ns/1ps
`include "clic_macros.svh"

module clic_ctrl
  import clic_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_i,
  input  csr_req_t             csr_req_i,
  input  addr_t                pc_i,
  input  best_t                best_i,
  input  stack_entry_t         top_i,
  input  prio_t                depth_i,
  input  word_t                table_rdata_i,
  input  logic                 table_hit_i,
  input  word_t                count_i,
  output prio_t                thresh_o,
  output logic                 push_o,
  output logic                 pop_o,
  output stack_entry_t         push_data_o,
  output logic [`VEC_SIZE-1:0] hw_clear_o,
  output logic                 timer_clear_o,
  output addr_t                target_addr_o,
  output pc_sel_e              pc_sel_o,
  output logic                 irq_o,
  output word_t                csr_rdata_o
);

  prio_t       thresh_q;
  word_t       thresh_word;
  logic        thresh_wr;
  logic        is_ret;
  logic        vector_jump;  // take or tail
  irq_action_e action;

  assign is_ret      = (pc_i == `RETURN_MARKER);
  assign thresh_wr   = csr_writes(csr_req_i, `THRESH_ADDR);
  assign thresh_word = csr_apply(word_t'(thresh_q), csr_req_i);

  // a valid best already has prio >= threshold
  always_comb begin
    if (best_i.valid && (best_i.prio > thresh_q)) action = ACT_TAKE;
    else if (is_ret && best_i.valid)            action = ACT_TAIL;
    else if (is_ret)                             action = ACT_RETURN;
    else                                         action = ACT_NONE;
  end

  // hardware updates beat software so threshold and stack stay consistent
  always_ff @(posedge clk) begin
    if (rst_i) begin
      thresh_q <= '0;
    end else if (action == ACT_TAKE) begin
      thresh_q <= best_i.prio;
    end else if (action == ACT_RETURN) begin
      thresh_q <= top_i.thresh;
    end else if (thresh_wr) begin
      thresh_q <= thresh_word[`PRIO_WIDTH-1:0];
    end
  end

  assign vector_jump   = (action == ACT_TAKE) || (action == ACT_TAIL);
  assign push_o        = (action == ACT_TAKE);
  assign pop_o         = (action == ACT_RETURN);
  assign push_data_o   = '{addr: pc_i, thresh: thresh_q};
  assign hw_clear_o    = vector_jump ? ({{(`VEC_SIZE-1){1'b0}}, 1'b1} << best_i.index) : '0;
  assign timer_clear_o = vector_jump && (best_i.index == '0);  // entry 0 is the timer
  assign irq_o         = vector_jump;
  assign pc_sel_o      = (action == ACT_NONE) ? PC_NORMAL : PC_INTERRUPT;
  assign thresh_o      = thresh_q;

  always_comb begin
    case (action)
      ACT_TAKE, ACT_TAIL: target_addr_o = {best_i.vec, 2'b00};  // word to byte address
      ACT_RETURN:         target_addr_o = top_i.addr;
      default:            target_addr_o = pc_i;
    endcase
  end

  always_comb begin
    csr_rdata_o = '0;  // unmapped reads zero
    if (csr_req_i.addr == `TIMER_ADDR)       csr_rdata_o = count_i;
    else if (csr_req_i.addr == `THRESH_ADDR) csr_rdata_o = word_t'(thresh_q);
    else if (csr_req_i.addr == `DEPTH_ADDR)  csr_rdata_o = word_t'(depth_i);
    else if (table_hit_i)                    csr_rdata_o = table_rdata_i;
  end

  // the tail decision relies on a valid best never lying below the threshold
  a_best_above_thresh : assert property (@(posedge clk) disable iff (rst_i)
    best_i.valid |-> (best_i.prio >= thresh_q));

endmodule

/* verilog/clic_macros.svh */
// clic macros: table size, field widths and the CSR map of the interrupt controller
`ifndef CLIC_MACROS_SVH
`define CLIC_MACROS_SVH

// vector table shape
`define VEC_SIZE 8
`define PRIO_WIDTH 3
`define PRIO_LEVELS 8  // one level per priority, also the return stack size

// address widths
`define IMEM_ADDR_WIDTH 16  // byte addresses into instruction memory
`define CSR_ADDR_WIDTH 12

// csr map
`define TIMER_ADDR 12'h400
`define THRESH_ADDR 12'h347
`define DEPTH_ADDR 12'h348

// vector and entry csrs sit at base plus index
`define VEC_BASE 12'hb00
`define ENTRY_BASE 12'hb20

// pc value the cpu presents when a handler returns
`define RETURN_MARKER {`IMEM_ADDR_WIDTH{1'b1}}

`endif

/* verilog/clic_pkg.sv */
// clic package: shared types and csr helpers of the interrupt controller
`include "clic_macros.svh"

package clic_pkg;

  typedef logic [31:0] word_t;
  typedef logic [`PRIO_WIDTH-1:0] prio_t;
  typedef logic [$clog2(`VEC_SIZE)-1:0] idx_t;
  typedef logic [`IMEM_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`IMEM_ADDR_WIDTH-3:0] vec_addr_t;  // word address of a handler
  typedef logic [`CSR_ADDR_WIDTH-1:0] csr_addr_t;

  typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;
  typedef enum logic {PC_NORMAL, PC_INTERRUPT} pc_sel_e;
  typedef enum logic [1:0] {ACT_NONE, ACT_TAKE, ACT_TAIL, ACT_RETURN} irq_action_e;

  typedef struct packed {
    logic      enable;  // one cycle strobe
    csr_addr_t addr;
    csr_op_e   op;
    word_t     data;
  } csr_req_t;

  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pended;  // lsb
  } entry_t;

  typedef struct packed {
    addr_t addr;    // interrupted pc
    prio_t thresh;  // threshold before the take
  } stack_entry_t;

  typedef struct packed {
    logic      valid;
    idx_t      index;
    prio_t     prio;
    vec_addr_t vec;
  } best_t;

  // true when the request modifies the register at addr
  function automatic logic csr_writes(input csr_req_t req, input csr_addr_t addr);
    return req.enable && (req.op != CSR_NONE) && (req.addr == addr);
  endfunction

  // new register value for a write, set or clear
  function automatic word_t csr_apply(input word_t old_val, input csr_req_t req);
    word_t res;
    case (req.op)
      CSR_WRITE: res = req.data;
      CSR_SET:   res = old_val | req.data;
      CSR_CLEAR: res = old_val & ~req.data;
      default:   res = old_val;
    endcase
    return res;
  endfunction

endpackage

/* verilog/clic_priority_select.sv */
// clic priority select: finds the highest enabled and pended entry at or above threshold
`timescale 1ns/1ps
`include "clic_macros.svh"

module clic_priority_select
  import clic_pkg::*;
(
  input  entry_t    entries_i [`VEC_SIZE],
  input  vec_addr_t vectors_i [`VEC_SIZE],
  input  prio_t     thresh_i,
  output best_t     best_o
);

  // linear scan, >= lets a later index win a tie
  always_comb begin
    prio_t max_prio;
    max_prio = thresh_i;  // running maximum starts at the threshold
    best_o   = '0;
    for (int k = 0; k < `VEC_SIZE; k++) begin
      if (entries_i[k].enabled && entries_i[k].pended &&
          (entries_i[k].prio >= max_prio)) begin
        max_prio     = entries_i[k].prio;
        best_o.valid = 1'b1;
        best_o.index = idx_t'(k);
        best_o.prio  = entries_i[k].prio;
        best_o.vec   = vectors_i[k];
      end
    end
  end

endmodule

/* verilog/clic_return_stack.sv */
// clic return stack: lifo of interrupted pc and saved threshold with depth count
`timescale 1ns/1ps
`include "clic_macros.svh"

module clic_return_stack
  import clic_pkg::*;
(
  input  logic         clk,
  input  logic         rst_i,
  input  logic         push_i,
  input  logic         pop_i,
  input  stack_entry_t data_i,
  output stack_entry_t top_o,
  output prio_t        depth_o
);

  stack_entry_t mem_q [`PRIO_LEVELS];
  prio_t        depth_q;  // number of live items

  always_ff @(posedge clk) begin
    if (rst_i) begin
      depth_q <= '0;
    end else if (push_i) begin
      depth_q <= depth_q + 1'b1;
    end else if (pop_i) begin
      depth_q <= depth_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) mem_q[depth_q] <= data_i;
  end

  assign top_o   = (depth_q == '0) ? '0 : mem_q[depth_q - 1'b1];
  assign depth_o = depth_q;

  // nesting is bounded by the strictly rising threshold in ctrl
  a_no_overflow : assert property (@(posedge clk) disable iff (rst_i)
    push_i |-> (depth_q != '1));
  a_no_underflow : assert property (@(posedge clk) disable iff (rst_i)
    pop_i |-> (depth_q != '0));
  a_no_push_pop : assert property (@(posedge clk) disable iff (rst_i)
    !(push_i && pop_i));

endmodule

/* verilog/clic_timer.sv */
// clic timer: csr down-counter that raises a sticky pend request for entry 0
`timescale 1ns/1ps
`include "clic_macros.svh"

module clic_timer
  import clic_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  csr_req_t csr_req_i,
  input  logic     timer_clear_i,
  output word_t    count_o,
  output logic     timer_pend_o
);

  word_t count_q;
  logic  pend_q;
  logic  count_wr;

  assign count_wr = csr_writes(csr_req_i, `TIMER_ADDR);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (count_wr) begin
      count_q <= csr_apply(count_q, csr_req_i);  // software load wins
    end else if (count_q != '0) begin
      count_q <= count_q - 32'd1;
    end
  end

  // expiry is the 1 -> 0 step, so the flag rises with the zero count
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pend_q <= 1'b0;
    end else if (timer_clear_i) begin
      pend_q <= 1'b0;
    end else if (!count_wr && (count_q == 32'd1)) begin
      pend_q <= 1'b1;
    end
  end

  assign count_o      = count_q;
  assign timer_pend_o = pend_q;

  // a fresh pend is only seen together with an expired counter
  a_pend_on_zero : assert property (@(posedge clk) disable iff (rst_i)
    $rose(pend_q) |-> (count_q == '0));

endmodule

/* verilog/clic_top.sv */
// clic top: core-local interrupt controller built from timer, table, select, stack and ctrl
`timescale 1ns/1ps
`include "clic_macros.svh"

module clic_top
  import clic_pkg::*;
(
  input  logic     clk,
  input  logic     rst_i,
  input  csr_req_t csr_req_i,
  input  addr_t    pc_i,
  output word_t    csr_rdata_o,
  output addr_t    target_addr_o,
  output pc_sel_e  pc_sel_o,
  output prio_t    level_o,  // return stack depth
  output logic     irq_o
);

  logic                 timer_pend;
  logic                 timer_clear;
  word_t                count;
  entry_t               entries [`VEC_SIZE];
  vec_addr_t            vectors [`VEC_SIZE];
  word_t                table_rdata;
  logic                 table_hit;
  logic [`VEC_SIZE-1:0] hw_clear;
  best_t                best;
  prio_t                thresh;
  logic                 push;
  logic                 pop;
  stack_entry_t         push_data;
  stack_entry_t         top;
  prio_t                depth;

  clic_timer u_timer (
    .clk, .rst_i, .csr_req_i,
    .timer_clear_i(timer_clear),
    .count_o(count),
    .timer_pend_o(timer_pend)
  );

  clic_vector_table u_table (
    .clk, .rst_i, .csr_req_i,
    .timer_pend_i(timer_pend),
    .hw_clear_i(hw_clear),
    .entries_o(entries),
    .vectors_o(vectors),
    .rdata_o(table_rdata),
    .hit_o(table_hit)
  );

  clic_priority_select u_select (
    .entries_i(entries), .vectors_i(vectors), .thresh_i(thresh), .best_o(best)
  );

  clic_return_stack u_stack (
    .clk, .rst_i, .push_i(push), .pop_i(pop),
    .data_i(push_data), .top_o(top), .depth_o(depth)
  );

  clic_ctrl u_ctrl (
    .clk, .rst_i, .csr_req_i, .pc_i,
    .best_i(best), .top_i(top), .depth_i(depth),
    .table_rdata_i(table_rdata), .table_hit_i(table_hit), .count_i(count),
    .thresh_o(thresh), .push_o(push), .pop_o(pop), .push_data_o(push_data),
    .hw_clear_o(hw_clear), .timer_clear_o(timer_clear),
    .target_addr_o, .pc_sel_o, .irq_o, .csr_rdata_o
  );

  assign level_o = depth;

endmodule

/* verilog/clic_vector_table.sv */
// clic vector table: entry and vector csrs with readback and hardware pend updates
`timescale 1ns/1ps
`include "clic_macros.svh"

module clic_vector_table
  import clic_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_i,
  input  csr_req_t             csr_req_i,
  input  logic                 timer_pend_i,
  input  logic [`VEC_SIZE-1:0] hw_clear_i,   // one-hot pend clear from ctrl
  output entry_t               entries_o [`VEC_SIZE],
  output vec_addr_t            vectors_o [`VEC_SIZE],
  output word_t                rdata_o,
  output logic                 hit_o
);

  entry_t    entries_q [`VEC_SIZE];
  vec_addr_t vectors_q [`VEC_SIZE];

  logic [`VEC_SIZE-1:0] ent_sel;  // address decode, independent of enable
  logic [`VEC_SIZE-1:0] vec_sel;
  logic [`VEC_SIZE-1:0] ent_wr;
  logic [`VEC_SIZE-1:0] vec_wr;
  word_t                ent_word [`VEC_SIZE];
  word_t                vec_word [`VEC_SIZE];

  always_comb begin
    for (int k = 0; k < `VEC_SIZE; k++) begin
      ent_sel[k]  = csr_req_i.addr == csr_addr_t'(`ENTRY_BASE + k);
      vec_sel[k]  = csr_req_i.addr == csr_addr_t'(`VEC_BASE + k);
      ent_wr[k]   = csr_writes(csr_req_i, csr_addr_t'(`ENTRY_BASE + k));
      vec_wr[k]   = csr_writes(csr_req_i, csr_addr_t'(`VEC_BASE + k));
      ent_word[k] = csr_apply(word_t'(entries_q[k]), csr_req_i);
      vec_word[k] = csr_apply(word_t'(vectors_q[k]), csr_req_i);
    end
  end

  // a software write to an entry masks any hardware pend change that cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int k = 0; k < `VEC_SIZE; k++) begin
        entries_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `VEC_SIZE; k++) begin
        if (ent_wr[k]) begin
          entries_q[k] <= entry_t'(ent_word[k][$bits(entry_t)-1:0]);
        end else if (hw_clear_i[k]) begin
          entries_q[k].pended <= 1'b0;  // taken or tail-chained
        end else if ((k == 0) && timer_pend_i) begin
          entries_q[k].pended <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int k = 0; k < `VEC_SIZE; k++) begin
        vectors_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < `VEC_SIZE; k++) begin
        if (vec_wr[k]) vectors_q[k] <= vec_word[k][$bits(vec_addr_t)-1:0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    hit_o   = |{ent_sel, vec_sel};
    for (int k = 0; k < `VEC_SIZE; k++) begin
      if (ent_sel[k]) rdata_o = word_t'(entries_q[k]);
      if (vec_sel[k]) rdata_o = word_t'(vectors_q[k]);
    end
  end

  assign entries_o = entries_q;
  assign vectors_o = vectors_q;

  // ctrl clears at most one pend bit per cycle
  a_clear_onehot : assert property (@(posedge clk) disable iff (rst_i)
    $onehot0(hw_clear_i));

endmodule
